//--- Makefile
SIM  = obj_dir/Vtb_rect_draw
SRCS = $(shell grep -v '^+' sources.f)

.PHONY: all run clean

all: $(SIM)

$(SIM): sources.f $(SRCS) verilog/draw_settings.svh
	verilator --binary --timing --timescale 1ns/1ns --top-module tb_rect_draw -f sources.f

run: $(SIM)
	$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "Finished with errors" sim.log; then echo "FAIL"; exit 1; fi
	@if ! grep -q "Finished with no errors" sim.log; then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir sim.log

//--- sources.f
+incdir+verilog
verilog/draw_geom_pkg.sv
verilog/cmd_mem_pkg.sv
verilog/cmd_mem.sv
verilog/cmd_mem_arbiter.sv
verilog/rect_cmd_fetch.sv
verilog/rect_raster.sv
verilog/rect_draw_top.sv
test/tb_rect_draw.sv

//--- test/tb_rect_draw.sv
`timescale 1ns/1ns
`default_nettype none

`include "draw_settings.svh"

module tb_rect_draw;

	import cmd_mem_pkg::*;
	import draw_geom_pkg::*;

	logic              iCLK;
	logic              rst;
	mem_req_t          host_req;
	logic              host_grant;
	logic              host_rvalid;
	cmd_word_t         host_rdata;
	logic [`GAP_W-1:0] gap;
	logic              pix_valid;
	pix_write_t        pix;
	logic              pix_ack = 1'b0;

	// Error counters by kind
	int value_errs = 0;
	int other_errs = 0;
	int bus_errs = 0;

	// Frame-bus model state
	pix_write_t log_q[$];
	int         low_q[$];
	pix_write_t exp_q[$];
	int         valid_rises = 0;
	int         cycle = 0;
	int         last_ack_cycle = 0;
	int         ack_delay = 0;
	logic       ack_armed = 1'b0;
	logic       prev_valid = 1'b0;
	pix_write_t prev_pix = '0;

	rect_draw_top dut0 (
		.iCLK        (iCLK),
		.rst         (rst),
		.host_req    (host_req),
		.host_grant  (host_grant),
		.host_rvalid (host_rvalid),
		.host_rdata  (host_rdata),
		.gap         (gap),
		.pix_valid   (pix_valid),
		.pix         (pix),
		.pix_ack     (pix_ack)
	);

	initial begin
		iCLK = 1'b0;
		forever #4 iCLK = ~iCLK;
	end

	// ========================================
	// Frame-buffer bus model
	// ========================================
	initial begin
		// Acknowledge delays come from this process
		void'($urandom(74248));
		forever begin
			@(posedge iCLK);
			cycle = cycle + 1;
			if (rst) begin
				pix_ack <= 1'b0;
				ack_armed = 1'b0;
				prev_valid = 1'b0;
			end else begin
				if (pix_valid && pix_ack) begin
					// Write completes on this edge
					log_q.push_back(pix);
					last_ack_cycle = cycle;
					pix_ack <= 1'b0;
					ack_armed = 1'b0;
				end else if (pix_valid) begin
					if (!prev_valid) begin
						valid_rises = valid_rises + 1;
						// Idle cycles since the last acknowledge
						low_q.push_back(cycle - last_ack_cycle - 1);
					end else if (pix != prev_pix) begin
						bus_errs = bus_errs + 1;
						$display("pix changed while waiting for acknowledge");
					end
					// Random delay 0 to 5 before ack
					if (!ack_armed) begin
						ack_delay = $urandom_range(5, 0);
						ack_armed = 1'b1;
					end
					if (ack_delay == 0) begin
						pix_ack <= 1'b1;
					end else begin
						ack_delay = ack_delay - 1;
					end
				end else if (ack_armed) begin
					bus_errs = bus_errs + 1;
					ack_armed = 1'b0;
					$display("pix_valid dropped before the write was acknowledged");
				end
				prev_valid = pix_valid;
				prev_pix = pix;
			end
		end
	end

	// ========================================
	// Compare tasks
	// ========================================
	task automatic check_pix(input string name, input pix_write_t got, input pix_write_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_word(input string name, input cmd_word_t got, input cmd_word_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			value_errs++;
			$display("[FAIL] %s got %h expected %h", name, got, exp);
		end
	endtask

	// ========================================
	// Host port
	// ========================================
	task automatic host_write(input cmd_addr_t addr, input cmd_word_t data);
		int t;
		host_req <= '{valid: 1'b1, write: 1'b1, addr: addr, wdata: data};
		t = 0;
		do begin
			@(posedge iCLK);
			t++;
		end while (!host_grant && t < 50);
		if (!host_grant) begin
			other_errs++;
			$display("Host write to word %0d was never granted", addr);
		end
		host_req.valid <= 1'b0;
	endtask

	task automatic host_read(input cmd_addr_t addr, output cmd_word_t data);
		int t;
		host_req <= '{valid: 1'b1, write: 1'b0, addr: addr, wdata: '0};
		t = 0;
		do begin
			@(posedge iCLK);
			t++;
		end while (!host_grant && t < 50);
		if (!host_grant) begin
			other_errs++;
			$display("Host read of word %0d was never granted", addr);
		end
		host_req.valid <= 1'b0;
		t = 0;
		do begin
			@(posedge iCLK);
			t++;
		end while (!host_rvalid && t < 50);
		if (!host_rvalid) begin
			other_errs++;
			$display("Host read of word %0d returned no data", addr);
		end
		data = host_rdata;
	endtask

	// Words 1 to 5 on consecutive cycles
	task automatic read_back_words(input cmd_word_t exp [5]);
		cmd_word_t got[$];
		int        t;
		for (int i = 0; i < 5; i++) begin
			host_req <= '{valid: 1'b1, write: 1'b0, addr: cmd_addr_t'(i + 1), wdata: '0};
			@(posedge iCLK);
			if (host_rvalid) got.push_back(host_rdata);
		end
		host_req.valid <= 1'b0;
		t = 0;
		while (got.size() < 5 && t < 20) begin
			@(posedge iCLK);
			t++;
			if (host_rvalid) got.push_back(host_rdata);
		end
		check_count("burst read count", got.size(), 5);
		for (int i = 0; i < got.size() && i < 5; i++) begin
			check_word($sformatf("word %0d", i + 1), got[i], exp[i]);
		end
	endtask

	// Expected pixels in row-major order
	// Address is base + x + y * 1024
	function automatic void build_expected(input rect_t r);
		pix_write_t p;
		exp_q.delete();
		for (int y = int'(r.y1); y <= int'(r.y2); y++) begin
			for (int x = int'(r.x1); x <= int'(r.x2); x++) begin
				p.addr  = `DRAW_FRAME_BASE + pix_addr_t'(x) + pix_addr_t'(y * 1024);
				p.color = r.color;
				exp_q.push_back(p);
			end
		end
	endfunction

	// ========================================
	// One rectangle command
	// ========================================
	task automatic run_rect(input cmd_word_t x1w, input cmd_word_t y1w, input cmd_word_t x2w,
		input cmd_word_t y2w, input cmd_word_t colw, input logic [`GAP_W-1:0] gap_val,
		input logic burst);
		rect_t     r;
		cmd_word_t words [5];
		cmd_word_t w;
		int        polls;
		int        bursts;
		int        log_start;
		int        low_start;
		int        rises_start;
		// Painter keeps only the low bits of each word
		r.x1    = coord_t'(x1w);
		r.y1    = coord_t'(y1w);
		r.x2    = coord_t'(x2w);
		r.y2    = coord_t'(y2w);
		r.color = color_t'(colw);
		build_expected(r);
		words = '{x1w, y1w, x2w, y2w, colw};
		log_start = log_q.size();
		low_start = low_q.size();
		rises_start = valid_rises;
		gap <= gap_val;
		host_write(`CMD_X1, x1w);
		host_write(`CMD_Y1, y1w);
		host_write(`CMD_X2, x2w);
		host_write(`CMD_Y2, y2w);
		host_write(`CMD_COLOR, colw);
		host_write(`CMD_GO, 32'd1);
		// Host traffic competes with the fetcher until the raster is busy
		if (burst) begin
			bursts = 0;
			do begin
				read_back_words(words);
				bursts++;
			end while (valid_rises == rises_start && bursts < 40);
			if (valid_rises == rises_start) begin
				other_errs++;
				$display("Drawing never started under host read traffic");
			end
			// More reads while pixels go out
			repeat (2) read_back_words(words);
		end
		polls = 0;
		do begin
			host_read(`CMD_GO, w);
			polls++;
		end while (w != 0 && polls < 500);
		if (w != 0) begin
			other_errs++;
			$display("Drawing did not finish, word 0 is still set");
		end
		check_count("pixel writes", log_q.size() - log_start, exp_q.size());
		for (int i = 0; i < exp_q.size() && log_start + i < log_q.size(); i++) begin
			check_pix($sformatf("pix[%0d]", i), log_q[log_start + i], exp_q[i]);
		end
		for (int i = low_start; i < low_q.size(); i++) begin
			if (low_q[i] < int'(gap_val) + 1) begin
				other_errs++;
				$display("Only %0d idle cycles after an acknowledge with gap %0d",
					low_q[i], gap_val);
			end
		end
	endtask

	// ========================================
	// Test sequence
	// ========================================
	initial begin
		cmd_word_t w;
		rst = 1'b1;
		host_req = '0;
		gap = '0;
		repeat (5) @(posedge iCLK);
		rst <= 1'b0;

		// Idle painter with word 0 clear
		host_write(`CMD_GO, 32'd0);
		repeat (200) @(posedge iCLK);
		check_count("pix_valid rises while idle", valid_rises, 0);
		host_read(`CMD_GO, w);
		check_word("word 0", w, 32'd0);

		// Single pixel
		run_rect(32'd7, 32'd5, 32'd7, 32'd5, 32'h0000_00a5, 4'd0, 1'b0);
		// 4 by 3 block
		run_rect(32'd100, 32'd20, 32'd103, 32'd22, 32'h0000_003c, 4'd1, 1'b0);
		// Gap of 3 near the bottom of the screen
		run_rect(32'd510, 32'd1021, 32'd512, 32'd1022, 32'h0000_00e7, 4'd3, 1'b0);
		// Host reads during the command
		// Upper bits of each word are ignored
		run_rect(32'habcd_0002, 32'h1234_0008, 32'h0000_0004, 32'hf000_0009,
			32'h5555_aa5a, 4'd2, 1'b1);

		$display("Error counts: %0d value, %0d protocol, %0d bus",
			value_errs, other_errs, bus_errs);
		if (value_errs + other_errs + bus_errs == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/cmd_mem.sv
`timescale 1ns/1ns
`default_nettype none

`include "draw_settings.svh"

module cmd_mem (
	input  wire                   iCLK,
	input  wire cmd_mem_pkg::mem_req_t req,
	output cmd_mem_pkg::cmd_word_t     rdata
);

	import cmd_mem_pkg::*;

	// Shared command words
	cmd_word_t mem [`CMD_DEPTH];

	// Single port, one access per cycle
	always_ff @(posedge iCLK) begin
		if (req.valid && req.write) begin
			mem[req.addr] <= req.wdata;
		end
		// Read word shows up on the next cycle
		if (req.valid && !req.write) begin
			rdata <= mem[req.addr];
		end
	end

endmodule

`default_nettype wire

//--- verilog/cmd_mem_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module cmd_mem_arbiter (
	input  wire                        iCLK,
	input  wire                        rst,
	input  wire cmd_mem_pkg::mem_req_t host_req,
	input  wire cmd_mem_pkg::mem_req_t fetch_req,
	output logic                       host_grant,
	output logic                       fetch_grant,
	output logic                       host_rvalid,
	output logic                       fetch_rvalid,
	output cmd_mem_pkg::cmd_word_t     rdata
);

	import cmd_mem_pkg::*;

	// Request forwarded to the memory this cycle
	mem_req_t mem_req;

	// ========================================
	// Fixed priority, host first
	// ========================================
	always_comb begin
		host_grant  = host_req.valid;
		fetch_grant = fetch_req.valid && !host_req.valid;
		if (host_req.valid) begin
			mem_req = host_req;
		end else begin
			mem_req = fetch_req;
		end
	end

	// Remember who issued the read, data is one cycle behind
	always_ff @(posedge iCLK) begin
		if (rst) begin
			host_rvalid  <= 1'b0;
			fetch_rvalid <= 1'b0;
		end else begin
			host_rvalid  <= host_grant && !host_req.write;
			fetch_rvalid <= fetch_grant && !fetch_req.write;
		end
	end

	// Read data is shared, rvalid says whose it is
	cmd_mem u_mem (
		.iCLK  (iCLK),
		.req   (mem_req),
		.rdata (rdata)
	);

endmodule

`default_nettype wire

//--- verilog/cmd_mem_pkg.sv
`default_nettype none

`include "draw_settings.svh"

package cmd_mem_pkg;

	// Word address into the command memory
	typedef logic [`CMD_ADDR_W-1:0] cmd_addr_t;

	// One command word
	typedef logic [`CMD_WORD_W-1:0] cmd_word_t;

	// Request from one peer of the memory
	// Held until granted, write clear means read
	typedef struct packed {
		logic      valid;
		logic      write;
		cmd_addr_t addr;
		cmd_word_t wdata;
	} mem_req_t;

endpackage

`default_nettype wire

//--- verilog/draw_geom_pkg.sv
`default_nettype none

`include "draw_settings.svh"

package draw_geom_pkg;

	// Screen coordinate, x or y
	typedef logic [`DRAW_COORD_W-1:0] coord_t;

	// Pixel colour as stored in the frame buffer
	typedef logic [`DRAW_COLOR_W-1:0] color_t;

	// Byte address on the frame-buffer bus
	typedef logic [`DRAW_PIX_ADDR_W-1:0] pix_addr_t;

	// Rectangle command
	// Corners are inclusive, x1 <= x2 and y1 <= y2
	typedef struct packed {
		coord_t x1;
		coord_t y1;
		coord_t x2;
		coord_t y2;
		color_t color;
	} rect_t;

	// One pixel write on the frame-buffer bus
	typedef struct packed {
		pix_addr_t addr;
		color_t    color;
	} pix_write_t;

endpackage

`default_nettype wire

//--- verilog/draw_settings.svh
`ifndef DRAW_SETTINGS_SVH
`define DRAW_SETTINGS_SVH

// ========================================
// Screen geometry and pixel bus
// ========================================
`define DRAW_COORD_W    10
`define DRAW_COLOR_W    8
`define DRAW_PIX_ADDR_W 32
// One row is 1024 pixels wide in the frame buffer
`define DRAW_ROW_SHIFT  10
`define DRAW_FRAME_BASE 32'h0000_0000

// ========================================
// Command memory
// ========================================
`define CMD_ADDR_W 8
`define CMD_DEPTH  256
`define CMD_WORD_W 32

// Word map, host sets word 0 to start a command
`define CMD_GO    8'd0
`define CMD_X1    8'd1
`define CMD_Y1    8'd2
`define CMD_X2    8'd3
`define CMD_Y2    8'd4
`define CMD_COLOR 8'd5

// Idle gap between pixel writes
`define GAP_W 4

`endif

//--- verilog/rect_cmd_fetch.sv
`timescale 1ns/1ns
`default_nettype none

`include "draw_settings.svh"

module rect_cmd_fetch (
	input  wire                         iCLK,
	input  wire                         rst,
	output cmd_mem_pkg::mem_req_t       fetch_req,
	input  wire                         fetch_grant,
	input  wire                         fetch_rvalid,
	input  wire cmd_mem_pkg::cmd_word_t rdata,
	output draw_geom_pkg::rect_t        rect,
	output logic                        start,
	input  wire                         done
);

	import cmd_mem_pkg::*;
	import draw_geom_pkg::*;

	typedef enum logic [1:0] {
		s_poll,
		s_load,
		s_draw,
		s_finish
	} state_t;

	state_t    state;
	// Read granted, waiting for its data
	logic      rd_wait;
	// Word being read in the load phase
	cmd_addr_t cur_addr;
	rect_t     rect_q;

	assign rect = rect_q;

	// ========================================
	// Command sequencer
	// ========================================
	always_ff @(posedge iCLK) begin
		if (rst) begin
			state     <= s_poll;
			fetch_req <= '0;
			rd_wait   <= 1'b0;
			start     <= 1'b0;
			cur_addr  <= `CMD_X1;
		end else begin
			start <= 1'b0;

			// Drop the request once the arbiter takes it
			if (fetch_req.valid && fetch_grant) begin
				fetch_req.valid <= 1'b0;
				rd_wait         <= !fetch_req.write;
			end

			case (state)
				s_poll: begin
					// Keep reading the go word
					if (!fetch_req.valid && !rd_wait) begin
						fetch_req <= '{valid: 1'b1, write: 1'b0, addr: `CMD_GO, wdata: '0};
					end
					if (rd_wait && fetch_rvalid) begin
						rd_wait <= 1'b0;
						if (rdata != '0) begin
							state    <= s_load;
							cur_addr <= `CMD_X1;
						end
					end
				end

				s_load: begin
					// Words 1 to 5, one read at a time
					if (!fetch_req.valid && !rd_wait) begin
						fetch_req <= '{valid: 1'b1, write: 1'b0, addr: cur_addr, wdata: '0};
					end
					if (rd_wait && fetch_rvalid) begin
						rd_wait <= 1'b0;
						// Only the low bits of each word count
						case (cur_addr)
							`CMD_X1:    rect_q.x1    <= rdata[`DRAW_COORD_W-1:0];
							`CMD_Y1:    rect_q.y1    <= rdata[`DRAW_COORD_W-1:0];
							`CMD_X2:    rect_q.x2    <= rdata[`DRAW_COORD_W-1:0];
							`CMD_Y2:    rect_q.y2    <= rdata[`DRAW_COORD_W-1:0];
							`CMD_COLOR: rect_q.color <= rdata[`DRAW_COLOR_W-1:0];
							default: ;
						endcase
						if (cur_addr == `CMD_COLOR) begin
							state <= s_draw;
							start <= 1'b1;
						end else begin
							cur_addr <= cur_addr + 1'b1;
						end
					end
				end

				s_draw: begin
					// Raster owns the bus until done
					if (done) begin
						state <= s_finish;
					end
				end

				s_finish: begin
					// Clearing the go word tells the host we are finished
					if (!fetch_req.valid) begin
						fetch_req <= '{valid: 1'b1, write: 1'b1, addr: `CMD_GO, wdata: '0};
					end else if (fetch_grant) begin
						state <= s_poll;
					end
				end

				default: state <= s_poll;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/rect_draw_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "draw_settings.svh"

module rect_draw_top (
	input  wire                         iCLK,
	input  wire                         rst,
	input  wire cmd_mem_pkg::mem_req_t  host_req,
	output logic                        host_grant,
	output logic                        host_rvalid,
	output cmd_mem_pkg::cmd_word_t      host_rdata,
	input  wire [`GAP_W-1:0]            gap,
	output logic                        pix_valid,
	output draw_geom_pkg::pix_write_t   pix,
	input  wire                         pix_ack
);

	import cmd_mem_pkg::*;
	import draw_geom_pkg::*;

	// Fetcher side of the command memory
	mem_req_t fetch_req;
	logic     fetch_grant;
	logic     fetch_rvalid;

	// Fetcher to raster handoff
	rect_t    rect;
	logic     start;
	logic     done;

	// Read data is shared by both peers
	cmd_mem_arbiter u_arb (
		.iCLK         (iCLK),
		.rst          (rst),
		.host_req     (host_req),
		.fetch_req    (fetch_req),
		.host_grant   (host_grant),
		.fetch_grant  (fetch_grant),
		.host_rvalid  (host_rvalid),
		.fetch_rvalid (fetch_rvalid),
		.rdata        (host_rdata)
	);

	rect_cmd_fetch u_fetch (
		.iCLK         (iCLK),
		.rst          (rst),
		.fetch_req    (fetch_req),
		.fetch_grant  (fetch_grant),
		.fetch_rvalid (fetch_rvalid),
		.rdata        (host_rdata),
		.rect         (rect),
		.start        (start),
		.done         (done)
	);

	// Pixel writer on the frame-buffer bus
	rect_raster u_raster (
		.iCLK      (iCLK),
		.rst       (rst),
		.rect      (rect),
		.start     (start),
		.gap       (gap),
		.pix_valid (pix_valid),
		.pix       (pix),
		.pix_ack   (pix_ack),
		.done      (done)
	);

endmodule

`default_nettype wire

//--- verilog/rect_raster.sv
`timescale 1ns/1ns
`default_nettype none

`include "draw_settings.svh"

module rect_raster (
	input  wire                       iCLK,
	input  wire                       rst,
	input  wire draw_geom_pkg::rect_t rect,
	input  wire                       start,
	input  wire [`GAP_W-1:0]          gap,
	output logic                      pix_valid,
	output draw_geom_pkg::pix_write_t pix,
	input  wire                       pix_ack,
	output logic                      done
);

	import draw_geom_pkg::*;

	typedef enum logic [1:0] {
		s_idle,
		s_write,
		s_gap,
		s_done
	} state_t;

	state_t           state;
	rect_t            rect_q;
	// Cursor of the pixel being written
	coord_t           x;
	coord_t           y;
	logic [`GAP_W-1:0] gap_cnt;

	// ========================================
	// Pixel bus outputs
	// ========================================
	assign pix_valid = (state == s_write);
	assign done      = (state == s_done);

	// Address is base + x + y * row stride
	always_comb begin
		pix.addr  = `DRAW_FRAME_BASE + pix_addr_t'(x)
			+ (pix_addr_t'(y) << `DRAW_ROW_SHIFT);
		pix.color = rect_q.color;
	end

	// ========================================
	// Scan state machine
	// ========================================
	always_ff @(posedge iCLK) begin
		if (rst) begin
			state   <= s_idle;
			gap_cnt <= '0;
		end else begin
			case (state)
				s_idle: begin
					if (start) begin
						rect_q <= rect;
						x      <= rect.x1;
						y      <= rect.y1;
						state  <= s_write;
					end
				end

				s_write: begin
					// Hold the pixel until the frame buffer takes it
					if (pix_ack) begin
						if (x == rect_q.x2 && y == rect_q.y2) begin
							state <= s_done;
						end else begin
							state   <= s_gap;
							gap_cnt <= '0;
						end
					end
				end

				s_gap: begin
					// gap+1 idle cycles, gap read live
					if (gap_cnt >= gap) begin
						state <= s_write;
						// Row-major step
						if (x == rect_q.x2) begin
							x <= rect_q.x1;
							y <= y + 1'b1;
						end else begin
							x <= x + 1'b1;
						end
					end else begin
						gap_cnt <= gap_cnt + 1'b1;
					end
				end

				s_done: begin
					// Single cycle done pulse
					state <= s_idle;
				end

				default: state <= s_idle;
			endcase
		end
	end

endmodule

`default_nettype wire
